//--- compile.f
logic/bus_timing_pkg.sv
logic/eeprom_cmd_pkg.sv
logic/cond_if.sv
logic/byte_if.sv
logic/bus_cond_gen.sv
logic/bus_byte_shifter.sv
logic/eeprom_sequencer.sv
logic/eeprom_ctrl_top.sv
testbench/eeprom_slave_model.sv
testbench/tb_checker.sv
testbench/tb_eeprom_ctrl.sv

//--- logic/bus_byte_shifter.sv
`timescale 1ns/100ps

module bus_byte_shifter
(
    input logic CLK,
    input logic RESET,
    input logic sda_i,
    byte_if.engine bif
);

    logic running;
    logic [bus_timing_pkg::PHASE_W-1:0] ph_cnt;
    logic [3:0] bit_cnt; // 0..7 data, 8 acknowledge
    logic [7:0] sh;
    logic sda_bit; // line level, 1 released
    logic ack_bit;
    logic bit_start;
    logic sample;
    logic bit_end;

    assign ack_bit = bit_cnt == 4'd8;
    assign bit_start = running && ph_cnt == '0;
    assign sample = running && ph_cnt == bus_timing_pkg::SAMPLE_PH;
    assign bit_end = ph_cnt == bus_timing_pkg::LAST_PH;

    assign bif.scl_high = running && ph_cnt >= bus_timing_pkg::HIGH_PH;
    assign bif.sda_low = running && !sda_bit;
    assign bif.done = running && ack_bit && bit_end;
    assign bif.rx_byte = sh;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            running <= 1'b0;
            ph_cnt <= '0;
            bit_cnt <= '0;
            sda_bit <= 1'b1;
            bif.ack_in <= 1'b0;
        end
        else if (bif.go)
        begin
            running <= 1'b1;
            ph_cnt <= '0;
            bit_cnt <= '0;
            sda_bit <= 1'b1;
        end
        else if (running)
        begin
            // new level lands one cycle into the low half
            if (bit_start)
            begin
                if (ack_bit)
                begin
                    sda_bit <= bif.receive ? bif.ack_out : 1'b1;
                end
                else
                begin
                    sda_bit <= bif.receive ? 1'b1 : sh[7];
                end
            end
            if (sample && ack_bit && !bif.receive)
            begin
                bif.ack_in <= !sda_i; // slave pulls low to acknowledge
            end
            if (bit_end)
            begin
                ph_cnt <= '0;
                bit_cnt <= bit_cnt + 1'b1;
                running <= !ack_bit;
            end
            else
            begin
                ph_cnt <= ph_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (bif.go)
        begin
            sh <= bif.tx_byte;
        end
        else if (bit_start && !ack_bit && !bif.receive)
        begin
            sh <= {sh[6:0], 1'b0}; // msb first
        end
        else if (sample && !ack_bit && bif.receive)
        begin
            sh <= {sh[6:0], sda_i};
        end
    end

endmodule

//--- logic/bus_cond_gen.sv
`timescale 1ns/100ps

module bus_cond_gen
(
    input logic CLK,
    input logic RESET,
    cond_if.engine cif
);

    logic running;
    logic [bus_timing_pkg::PHASE_W-1:0] ph_cnt;
    logic stop_q;
    logic high_half;

    assign high_half = ph_cnt >= bus_timing_pkg::HIGH_PH;

    // start and repeated start keep scl high, stop raises it halfway
    assign cif.scl_high = running && (!stop_q || high_half);
    assign cif.sda_low = running && (stop_q ? ph_cnt != bus_timing_pkg::LAST_PH : high_half);
    assign cif.done = running && ph_cnt == bus_timing_pkg::LAST_PH;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            running <= 1'b0;
            ph_cnt <= '0;
        end
        else if (cif.go)
        begin
            running <= 1'b1;
            ph_cnt <= '0;
        end
        else if (running)
        begin
            if (ph_cnt == bus_timing_pkg::LAST_PH)
            begin
                running <= 1'b0;
                ph_cnt <= '0;
            end
            else
            begin
                ph_cnt <= ph_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cif.go)
        begin
            stop_q <= cif.kind == bus_timing_pkg::COND_STOP;
        end
    end

endmodule

//--- logic/bus_timing_pkg.sv
package bus_timing_pkg;

    localparam int SCL_HALF = 2; // CLK cycles per bus clock half
    localparam int BIT_PERIOD = 2 * SCL_HALF;
    localparam int PHASE_W = $clog2(BIT_PERIOD);

    // phase counter marks inside one bus clock period
    localparam logic [PHASE_W-1:0] LAST_PH = PHASE_W'(BIT_PERIOD - 1);
    localparam logic [PHASE_W-1:0] HIGH_PH = PHASE_W'(SCL_HALF); // first high cycle
    localparam logic [PHASE_W-1:0] SAMPLE_PH = PHASE_W'(SCL_HALF + (SCL_HALF - 1) / 2);

    typedef enum logic [1:0]
    {
        COND_START   = 2'd0,
        COND_RESTART = 2'd1,
        COND_STOP    = 2'd2
    } cond_kind_t;

endpackage

//--- logic/byte_if.sv
`timescale 1ns/100ps

interface byte_if;

    logic go;
    logic receive; // 1 shifts a byte in
    logic [7:0] tx_byte;
    logic ack_out; // line level in the ninth bit of a read
    logic done;
    logic [7:0] rx_byte;
    logic ack_in;
    logic sda_low;
    logic scl_high;

    modport sequencer (output go, output receive, output tx_byte, output ack_out,
                       input done, input rx_byte, input ack_in, input sda_low, input scl_high);

    modport engine (input go, input receive, input tx_byte, input ack_out,
                    output done, output rx_byte, output ack_in, output sda_low, output scl_high);

endinterface

//--- logic/cond_if.sv
`timescale 1ns/100ps

interface cond_if;

    logic go;
    bus_timing_pkg::cond_kind_t kind;
    logic done;
    logic sda_low;
    logic scl_high;

    modport sequencer (output go, output kind, input done, input sda_low, input scl_high);

    modport engine (input go, input kind, output done, output sda_low, output scl_high);

endinterface

//--- logic/eeprom_cmd_pkg.sv
package eeprom_cmd_pkg;

    localparam int ADDR_W = 11; // 2 KB array
    localparam int BLK_W = ADDR_W - 8; // block bits carried in the control byte

    localparam logic [3:0] DEVICE_CODE = 4'b1010;
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ = 1'b1;

    typedef enum logic [9:0]
    {
        S_IDLE    = 10'b00_0000_0001,
        S_START   = 10'b00_0000_0010,
        S_CTRL_WR = 10'b00_0000_0100,
        S_ADDR    = 10'b00_0000_1000,
        S_DATA_WR = 10'b00_0001_0000,
        S_RESTART = 10'b00_0010_0000,
        S_CTRL_RD = 10'b00_0100_0000,
        S_DATA_RD = 10'b00_1000_0000,
        S_STOP    = 10'b01_0000_0000,
        S_DONE    = 10'b10_0000_0000
    } seq_state_t;

endpackage

//--- logic/eeprom_ctrl_top.sv
`timescale 1ns/100ps

module eeprom_ctrl_top
(
    input logic CLK,
    input logic RESET,
    input logic wr,
    input logic rd,
    input logic [eeprom_cmd_pkg::ADDR_W-1:0] addr,
    input logic [7:0] wdata,
    input logic sda_i,
    output logic [7:0] rdata,
    output logic ack,
    output logic nack_err,
    output logic busy,
    output logic scl,
    output logic sda_oe
);

    cond_if cif ();
    byte_if bif ();

    eeprom_sequencer i_seq
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .ack      (ack),
        .nack_err (nack_err),
        .busy     (busy),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .cif      (cif.sequencer),
        .bif      (bif.sequencer)
    );

    bus_cond_gen i_cond
    (
        .CLK   (CLK),
        .RESET (RESET),
        .cif   (cif.engine)
    );

    bus_byte_shifter i_byte
    (
        .CLK   (CLK),
        .RESET (RESET),
        .sda_i (sda_i),
        .bif   (bif.engine)
    );

endmodule

//--- logic/eeprom_sequencer.sv
`timescale 1ns/100ps

module eeprom_sequencer
(
    input logic CLK,
    input logic RESET,
    input logic wr,
    input logic rd,
    input logic [eeprom_cmd_pkg::ADDR_W-1:0] addr,
    input logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic ack,
    output logic nack_err,
    output logic busy,
    output logic scl,
    output logic sda_oe,
    cond_if.sequencer cif,
    byte_if.sequencer bif
);

    eeprom_cmd_pkg::seq_state_t state;
    logic op_rd;
    logic [eeprom_cmd_pkg::ADDR_W-1:0] addr_q;
    logic [7:0] wdata_q;
    logic eng_run; // an engine owns the lines
    logic bus_idle;
    logic last_sda;
    logic accept;
    logic [7:0] ctrl_wr_byte;
    logic [7:0] ctrl_rd_byte;

    assign ctrl_wr_byte = {eeprom_cmd_pkg::DEVICE_CODE,
                           addr_q[eeprom_cmd_pkg::ADDR_W-1 -: eeprom_cmd_pkg::BLK_W],
                           eeprom_cmd_pkg::RW_WRITE};
    assign ctrl_rd_byte = {eeprom_cmd_pkg::DEVICE_CODE,
                           addr_q[eeprom_cmd_pkg::ADDR_W-1 -: eeprom_cmd_pkg::BLK_W],
                           eeprom_cmd_pkg::RW_READ};

    assign ack = state == eeprom_cmd_pkg::S_DONE;
    assign busy = !(state == eeprom_cmd_pkg::S_IDLE || ack);
    assign accept = !busy && (wr || rd);
    assign bif.ack_out = 1'b1; // single read ends with not-acknowledge

    // gaps between engines keep scl low and hold the last data level
    assign scl = eng_run ? (cif.scl_high | bif.scl_high) : bus_idle;
    assign sda_oe = eng_run ? (cif.sda_low | bif.sda_low) : last_sda;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= eeprom_cmd_pkg::S_IDLE;
            nack_err <= 1'b0;
            eng_run <= 1'b0;
            bus_idle <= 1'b1;
            last_sda <= 1'b0;
            rdata <= '0;
            cif.go <= 1'b0;
            bif.go <= 1'b0;
        end
        else
        begin
            cif.go <= 1'b0;
            bif.go <= 1'b0;
            if (cif.go || bif.go)
                eng_run <= 1'b1;
            else if (cif.done || bif.done)
                eng_run <= 1'b0;
            if (eng_run)
                last_sda <= cif.sda_low | bif.sda_low;
            if (cif.done)
                bus_idle <= cif.kind == bus_timing_pkg::COND_STOP;

            case (state)
                eeprom_cmd_pkg::S_IDLE, eeprom_cmd_pkg::S_DONE:
                begin
                    state <= eeprom_cmd_pkg::S_IDLE;
                    if (accept)
                    begin
                        op_rd <= !wr; // wr wins
                        addr_q <= addr;
                        wdata_q <= wdata;
                        nack_err <= 1'b0;
                        cif.go <= 1'b1;
                        cif.kind <= bus_timing_pkg::COND_START;
                        state <= eeprom_cmd_pkg::S_START;
                    end
                end
                eeprom_cmd_pkg::S_START, eeprom_cmd_pkg::S_RESTART:
                begin
                    if (cif.done)
                    begin
                        bif.go <= 1'b1;
                        bif.receive <= 1'b0;
                        if (state == eeprom_cmd_pkg::S_START)
                        begin
                            bif.tx_byte <= ctrl_wr_byte;
                            state <= eeprom_cmd_pkg::S_CTRL_WR;
                        end
                        else
                        begin
                            bif.tx_byte <= ctrl_rd_byte;
                            state <= eeprom_cmd_pkg::S_CTRL_RD;
                        end
                    end
                end
                eeprom_cmd_pkg::S_CTRL_WR, eeprom_cmd_pkg::S_ADDR,
                eeprom_cmd_pkg::S_DATA_WR, eeprom_cmd_pkg::S_CTRL_RD:
                begin
                    if (bif.done)
                    begin
                        if (!bif.ack_in || state == eeprom_cmd_pkg::S_DATA_WR)
                        begin
                            nack_err <= !bif.ack_in;
                            cif.go <= 1'b1;
                            cif.kind <= bus_timing_pkg::COND_STOP;
                            state <= eeprom_cmd_pkg::S_STOP;
                        end
                        else if (state == eeprom_cmd_pkg::S_CTRL_WR)
                        begin
                            bif.go <= 1'b1;
                            bif.tx_byte <= addr_q[7:0];
                            state <= eeprom_cmd_pkg::S_ADDR;
                        end
                        else if (state == eeprom_cmd_pkg::S_CTRL_RD)
                        begin
                            bif.go <= 1'b1;
                            bif.receive <= 1'b1;
                            state <= eeprom_cmd_pkg::S_DATA_RD;
                        end
                        else if (op_rd)
                        begin
                            cif.go <= 1'b1;
                            cif.kind <= bus_timing_pkg::COND_RESTART;
                            state <= eeprom_cmd_pkg::S_RESTART;
                        end
                        else
                        begin
                            bif.go <= 1'b1;
                            bif.tx_byte <= wdata_q;
                            state <= eeprom_cmd_pkg::S_DATA_WR;
                        end
                    end
                end
                eeprom_cmd_pkg::S_DATA_RD:
                begin
                    if (bif.done)
                    begin
                        cif.go <= 1'b1;
                        cif.kind <= bus_timing_pkg::COND_STOP;
                        state <= eeprom_cmd_pkg::S_STOP;
                    end
                end
                eeprom_cmd_pkg::S_STOP:
                begin
                    if (cif.done)
                    begin
                        if (op_rd && !nack_err)
                            rdata <= bif.rx_byte; // shows in the ack cycle
                        state <= eeprom_cmd_pkg::S_DONE;
                    end
                end
                default:
                    state <= eeprom_cmd_pkg::S_IDLE;
            endcase
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the EEPROM controller testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --top-module tb_eeprom_ctrl -f compile.f -o sim_eeprom \
    > build.log 2>&1 \
    && ./obj_dir/sim_eeprom > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -qx "all tests passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }

//--- testbench/eeprom_slave_model.sv
`timescale 1ns/100ps

module eeprom_slave_model
(
    input logic scl,
    input logic sda,
    output logic sda_pull
);

    localparam int P_CTRL = 0;
    localparam int P_ADDR = 1;
    localparam int P_WDATA = 2;
    localparam int P_READ = 3;
    localparam int P_NONE = 4;
    localparam logic [2:0] FIRST_ABSENT = 3'd6; // blocks 6 and 7 not fitted

    logic [7:0] mem [0:2**eeprom_cmd_pkg::ADDR_W-1];
    logic [7:0] sh = 8'h00;
    logic [7:0] rbyte = 8'hff;
    logic [7:0] lo_addr = 8'h00;
    logic [2:0] blk = 3'd0;
    logic reading = 1'b0;
    logic active = 1'b0;
    logic pull = 1'b0;
    logic scl_q = 1'b1;
    logic sda_q = 1'b1;
    int bit_cnt = 0;
    int phase = P_NONE;

    assign sda_pull = pull;

    initial
    begin
        for (int i = 0; i < 2**eeprom_cmd_pkg::ADDR_W; i++)
            mem[i] = 8'hff;
    end

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
        begin
            active = sda === 1'b0; // fall is start, rise is stop
            bit_cnt = 0;
            phase = active ? P_CTRL : P_NONE;
            pull = 1'b0;
        end
        else if (scl === 1'b1 && scl_q !== 1'b1 && active)
        begin
            if (bit_cnt < 8 && phase != P_READ)
                sh = {sh[6:0], sda};
            bit_cnt++;
        end
        else if (scl !== 1'b1 && scl_q === 1'b1 && active)
        begin
            if (bit_cnt == 8)
            begin
                pull = 1'b0;
                case (phase)
                    P_CTRL:
                    begin
                        blk = sh[3:1];
                        reading = sh[0];
                        pull = sh[7:4] == eeprom_cmd_pkg::DEVICE_CODE && blk < FIRST_ABSENT;
                        if (!pull)
                            phase = P_NONE;
                    end
                    P_ADDR:
                    begin
                        lo_addr = sh;
                        pull = 1'b1;
                    end
                    P_WDATA:
                    begin
                        mem[{blk, lo_addr}] = sh;
                        pull = 1'b1;
                    end
                    default: ;
                endcase
            end
            else if (bit_cnt == 9)
            begin
                bit_cnt = 0;
                pull = 1'b0;
                case (phase)
                    P_CTRL: phase = reading ? P_READ : P_ADDR;
                    P_ADDR: phase = P_WDATA;
                    default: phase = P_NONE;
                endcase
                if (phase == P_READ)
                begin
                    rbyte = mem[{blk, lo_addr}];
                    pull = !rbyte[7]; // first bit goes out at once
                end
            end
            else if (phase == P_READ && bit_cnt > 0)
            begin
                pull = !rbyte[3'(7 - bit_cnt)];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/100ps

module tb_checker
(
    input logic CLK,
    input logic RESET,
    input logic ack,
    input logic busy,
    input logic nack_err,
    input logic [7:0] rdata,
    input logic scl,
    input logic sda_oe,
    input logic sda,
    input int test_num,
    input int test_op,
    input logic [eeprom_cmd_pkg::ADDR_W-1:0] test_addr,
    input logic [7:0] exp_rdata,
    input logic exp_nack,
    output int test_cnt,
    output int fail_cnt,
    output logic err_pending
);

    logic prev_scl;
    logic prev_sda;
    logic saw_start;
    logic saw_stop;
    logic test_bad;
    int rise_cnt; // scl rises since the last start

    assign err_pending = test_bad; // error seen after the last ack

    function automatic string op_name(input int op);
        case (op)
            0: return "write";
            1: return "read";
            default: return "read+busy wr";
        endcase
    endfunction

    // sampled mid cycle where every line is settled
    always @(negedge CLK)
    begin
        if (RESET)
        begin
            prev_scl = 1'b1;
            prev_sda = 1'b1;
            saw_start = 1'b0;
            saw_stop = 1'b0;
            test_bad = 1'b0;
            rise_cnt = 0;
            test_cnt = 0;
            fail_cnt = 0;
        end
        else
        begin
            if (!busy && (scl !== 1'b1 || sda_oe !== 1'b0))
            begin
                $display("bus not idle while busy is low in test %0d (scl %b, sda_oe %b)",
                         test_num, scl, sda_oe);
                test_bad = 1'b1;
            end
            if (scl && !prev_scl)
                rise_cnt++;
            if (scl && prev_scl && sda != prev_sda)
            begin
                // legal only from idle or right after a whole byte
                if (rise_cnt == 1 || (rise_cnt != 0 && rise_cnt % 9 != 1))
                begin
                    $display("data line changed while scl high inside a byte in test %0d (state %h)",
                             test_num, tb_eeprom_ctrl.i_dut.i_seq.state);
                    test_bad = 1'b1;
                end
                if (!sda)
                begin
                    saw_start = 1'b1;
                    saw_stop = 1'b0;
                    rise_cnt = 0;
                end
                else
                    saw_stop = 1'b1;
            end
            if (ack)
            begin
                if (!saw_start || !saw_stop)
                begin
                    $display("test %0d did not begin with a start and end with a stop", test_num);
                    test_bad = 1'b1;
                end
                if (nack_err !== exp_nack)
                begin
                    $display("** Error: test %0d nack_err = %h, expected %h",
                             test_num, nack_err, exp_nack);
                    test_bad = 1'b1;
                end
                if (rdata !== exp_rdata)
                begin
                    $display("** Error: test %0d rdata = %h, expected %h",
                             test_num, rdata, exp_rdata);
                    test_bad = 1'b1;
                end
                test_cnt++;
                if (test_bad)
                    fail_cnt++;
                $display("test %0d %s addr %h: %s", test_num, op_name(test_op), test_addr,
                         test_bad ? "FAILED" : "ok");
                test_bad = 1'b0;
                saw_start = 1'b0;
                saw_stop = 1'b0;
            end
            prev_scl = scl;
            prev_sda = sda;
        end
    end

endmodule

//--- testbench/tb_eeprom_ctrl.sv
`timescale 1ns/100ps

module tb_eeprom_ctrl;

    localparam int OP_WR = 0;
    localparam int OP_RD = 1;
    localparam int OP_RD_BUSY_WR = 2; // read with a wr strobe while busy
    localparam int WAIT_LIMIT = 2000;

    typedef struct {
        int op;
        logic [eeprom_cmd_pkg::ADDR_W-1:0] addr;
        logic [7:0] wdata;
        logic [7:0] exp_rdata;
        logic exp_nack;
    } entry_t;

    logic CLK;
    logic RESET;
    logic wr;
    logic rd;
    logic [eeprom_cmd_pkg::ADDR_W-1:0] addr;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic ack;
    logic nack_err;
    logic busy;
    logic scl;
    logic sda_oe;
    logic slave_low;
    logic sda_line;
    int test_num;
    int test_op;
    logic [eeprom_cmd_pkg::ADDR_W-1:0] test_addr;
    logic [7:0] exp_rdata;
    logic exp_nack;
    int test_cnt;
    int fail_cnt;
    logic err_pending;
    logic timed_out;
    entry_t tbl[$];
    logic [7:0] ref_mem [0:2**eeprom_cmd_pkg::ADDR_W-1];
    logic [7:0] last_rdata;

    assign sda_line = !(sda_oe || slave_low); // open drain

    always #2 CLK = ~CLK;

    eeprom_ctrl_top i_dut
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .sda_i    (sda_line),
        .rdata    (rdata),
        .ack      (ack),
        .nack_err (nack_err),
        .busy     (busy),
        .scl      (scl),
        .sda_oe   (sda_oe)
    );

    eeprom_slave_model i_slave
    (
        .scl      (scl),
        .sda      (sda_line),
        .sda_pull (slave_low)
    );

    tb_checker i_check
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .ack         (ack),
        .busy        (busy),
        .nack_err    (nack_err),
        .rdata       (rdata),
        .scl         (scl),
        .sda_oe      (sda_oe),
        .sda         (sda_line),
        .test_num    (test_num),
        .test_op     (test_op),
        .test_addr   (test_addr),
        .exp_rdata   (exp_rdata),
        .exp_nack    (exp_nack),
        .test_cnt    (test_cnt),
        .fail_cnt    (fail_cnt),
        .err_pending (err_pending)
    );

    // expected values follow the memory rules, rdata holds on writes and errors
    function automatic void add_entry(input int op, input logic [10:0] a, input logic [7:0] d);
        entry_t e;
        logic absent;
        absent = a[10:8] >= 3'd6;
        e.op = op;
        e.addr = a;
        e.wdata = d;
        e.exp_nack = absent;
        if (op == OP_WR)
        begin
            if (!absent)
                ref_mem[a] = d;
        end
        else if (!absent)
            last_rdata = ref_mem[a];
        e.exp_rdata = last_rdata;
        tbl.push_back(e);
    endfunction

    task automatic wait_ack(output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT)
        begin
            @(negedge CLK);
            seen = ack;
            n++;
        end
    endtask

    task automatic wait_busy(output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT)
        begin
            @(negedge CLK);
            seen = busy;
            n++;
        end
    endtask

    initial
    begin
        logic seen;
        logic [10:0] ra;
        logic [7:0] rv;
        CLK = 1'b0;
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wdata = '0;
        test_num = 0;
        test_op = 0;
        test_addr = '0;
        exp_rdata = '0;
        exp_nack = 1'b0;
        timed_out = 1'b0;
        last_rdata = 8'h00; // rdata after reset
        void'($urandom(32'h6828));
        for (int i = 0; i < 2**eeprom_cmd_pkg::ADDR_W; i++)
            ref_mem[i] = 8'hff;

        add_entry(OP_WR, 11'h123, 8'ha5);
        add_entry(OP_RD, 11'h123, 8'h00);
        add_entry(OP_WR, 11'h045, 8'h11);
        add_entry(OP_WR, 11'h145, 8'h22);
        add_entry(OP_WR, 11'h545, 8'h66);
        add_entry(OP_RD, 11'h045, 8'h00);
        add_entry(OP_RD, 11'h145, 8'h00);
        add_entry(OP_RD, 11'h545, 8'h00);
        add_entry(OP_RD, 11'h245, 8'h00); // never written
        add_entry(OP_WR, 11'h645, 8'h77); // absent block
        add_entry(OP_RD, 11'h645, 8'h00);
        add_entry(OP_RD, 11'h7aa, 8'h00);
        add_entry(OP_WR, 11'h0f0, 8'h3c);
        add_entry(OP_RD_BUSY_WR, 11'h0f0, 8'hc3);
        add_entry(OP_RD, 11'h0f0, 8'h00);
        for (int k = 0; k < 6; k++)
        begin
            ra = {3'($urandom % 6), 8'($urandom)};
            rv = 8'($urandom);
            add_entry(OP_WR, ra, rv);
            add_entry(OP_RD, ra, 8'h00);
        end

        repeat (5) @(posedge CLK);
        RESET <= 1'b0;

        for (int i = 0; i < tbl.size() && !timed_out; i++)
        begin
            @(posedge CLK);
            test_num <= i;
            test_op <= tbl[i].op;
            test_addr <= tbl[i].addr;
            exp_rdata <= tbl[i].exp_rdata;
            exp_nack <= tbl[i].exp_nack;
            wr <= tbl[i].op == OP_WR;
            rd <= tbl[i].op != OP_WR;
            addr <= tbl[i].addr;
            wdata <= tbl[i].op == OP_WR ? tbl[i].wdata : 8'h00;
            @(posedge CLK);
            wr <= 1'b0;
            rd <= 1'b0;
            if (tbl[i].op == OP_RD_BUSY_WR)
            begin
                wait_busy(seen);
                if (!seen)
                begin
                    $display("timeout: busy never rose in test %0d", i);
                    timed_out = 1'b1;
                end
                @(posedge CLK);
                wr <= 1'b1; // must be dropped by the DUT
                wdata <= tbl[i].wdata;
                @(posedge CLK);
                wr <= 1'b0;
            end
            wait_ack(seen);
            if (!seen)
            begin
                $display("timeout: no ack in test %0d after %0d cycles", i, WAIT_LIMIT);
                timed_out = 1'b1;
            end
        end

        repeat (4) @(negedge CLK);
        $display("%0d tests run, %0d with errors", test_cnt, fail_cnt);
        if (!timed_out && fail_cnt == 0 && err_pending !== 1'b1 && test_cnt == tbl.size())
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
